// ==== logic/uart_hub_pkg.sv ====
package uart_hub_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------

    localparam int data_width     = 8;      // Bits per serial character.
    localparam int num_channels   = 4;
    localparam int chan_width     = 2;      // Bits of a channel number.
    localparam int buffer_depth   = 16;
    localparam int addr_width     = $clog2(buffer_depth);
    localparam int count_width    = addr_width + 1;
    localparam int prescale_width = 16;

    // Bit timer holds eight times prescale.
    localparam int timer_width    = prescale_width + 3;
    localparam int bit_cnt_width  = $clog2(data_width);

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    // One buffer entry. Channel tag above the byte.
    typedef struct packed {
        logic [chan_width-1:0] chan;
        logic [data_width-1:0] data;
    } rx_entry_t;

    typedef enum logic [1:0] {
        state_idle,     // Waiting for a falling edge.
        state_start,    // Confirming the start bit at mid-bit.
        state_data,
        state_stop
    } rx_state_e;

endpackage

// ==== logic/buffer_write_if.sv ====
`timescale 1ns/1ps

// One write beat from the arbiter into the shared buffer.
interface buffer_write_if;

    logic                    valid;     // A channel has a byte to write.
    logic                    ready;     // Buffer is not full.
    uart_hub_pkg::rx_entry_t entry;     // Tagged byte of the winner.

    modport arbiter (
        output valid,
        output entry,
        input  ready
    );

    modport buffer (
        input  valid,
        input  entry,
        output ready
    );

endinterface

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    rxd,
    input  logic [uart_hub_pkg::prescale_width-1:0] prescale,
    output logic [uart_hub_pkg::data_width-1:0]     rx_data,
    output logic                                    rx_valid,
    input  logic                                    rx_ready,
    output logic                                    busy,
    output logic                                    frame_error,
    output logic                                    overrun_error
);

    uart_hub_pkg::rx_state_e state;

    logic                                   rxd_reg;
    logic [uart_hub_pkg::timer_width-1:0]   timer;
    logic [uart_hub_pkg::bit_cnt_width-1:0] bit_cnt;
    logic [uart_hub_pkg::data_width-1:0]    shift_reg;
    logic [uart_hub_pkg::timer_width-1:0]   bit_time;
    logic [uart_hub_pkg::timer_width-1:0]   half_time;
    logic                                   tick;
    logic                                   shift_en;
    logic                                   load_en;

    // ------------------------------------------------------------------------
    // Bit timing
    // ------------------------------------------------------------------------

    // A bit is 8 x prescale cycles. Half a bit less the edge register delay.
    assign bit_time  = {prescale, 3'b000} - uart_hub_pkg::timer_width'(1);
    assign half_time = {1'b0, prescale, 2'b00} - uart_hub_pkg::timer_width'(2);

    assign tick     = (timer == '0);
    assign shift_en = tick && (state == uart_hub_pkg::state_data);
    assign load_en  = tick && (state == uart_hub_pkg::state_stop) && rxd_reg;

    assign busy = (state != uart_hub_pkg::state_idle);

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= uart_hub_pkg::state_idle;
            rxd_reg       <= 1'b1;    // Line idles high.
            timer         <= '0;
            bit_cnt       <= '0;
            rx_valid      <= 1'b0;
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;
        end else begin
            rxd_reg       <= rxd;
            frame_error   <= 1'b0;
            overrun_error <= 1'b0;

            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end

            if (!tick) begin
                timer <= timer - 1'b1;
            end else begin
                case (state)
                    uart_hub_pkg::state_idle: begin
                        if (!rxd_reg) begin
                            timer <= half_time;
                            state <= uart_hub_pkg::state_start;
                        end
                    end
                    uart_hub_pkg::state_start: begin
                        if (!rxd_reg) begin
                            timer   <= bit_time;
                            bit_cnt <= '0;
                            state   <= uart_hub_pkg::state_data;
                        end else begin
                            state <= uart_hub_pkg::state_idle;   // Glitch.
                        end
                    end
                    uart_hub_pkg::state_data: begin
                        timer   <= bit_time;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == uart_hub_pkg::bit_cnt_width'(uart_hub_pkg::data_width - 1)) begin
                            state <= uart_hub_pkg::state_stop;
                        end
                    end
                    uart_hub_pkg::state_stop: begin
                        state <= uart_hub_pkg::state_idle;
                        if (rxd_reg) begin
                            rx_valid      <= 1'b1;
                            overrun_error <= rx_valid && !rx_ready;  // Held byte lost.
                        end else begin
                            frame_error <= 1'b1;
                        end
                    end
                    default: state <= uart_hub_pkg::state_idle;
                endcase
            end
        end
    end

    // ------------------------------------------------------------------------
    // Data path
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_reg <= {rxd_reg, shift_reg[uart_hub_pkg::data_width-1:1]};  // LSB first.
        end
        if (load_en) begin
            rx_data <= shift_reg;
        end
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    a_one_error: assert property (
        @(posedge clk) disable iff (rst)
        !(frame_error && overrun_error)
    );

    // Held byte only changes when a new stop bit lands on it.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (rst)
        rx_valid && !rx_ready && !(tick && state == uart_hub_pkg::state_stop)
        |=> $stable(rx_data)
    );

endmodule

// ==== logic/write_arbiter.sv ====
`timescale 1ns/1ps

module write_arbiter (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [uart_hub_pkg::num_channels-1:0] rx_valid,
    input  logic [uart_hub_pkg::num_channels-1:0][uart_hub_pkg::data_width-1:0] rx_data,
    output logic [uart_hub_pkg::num_channels-1:0] rx_ready,
    buffer_write_if.arbiter                       wr
);

    logic [uart_hub_pkg::chan_width-1:0] ptr;      // Highest priority channel.
    logic [uart_hub_pkg::chan_width-1:0] winner;
    logic [uart_hub_pkg::chan_width-1:0] idx;
    logic                                found;

    // ------------------------------------------------------------------------
    // Rotating priority search
    // ------------------------------------------------------------------------

    always_comb begin
        found  = 1'b0;
        winner = ptr;
        idx    = ptr;
        for (int i = 0; i < uart_hub_pkg::num_channels; i++) begin
            idx = ptr + uart_hub_pkg::chan_width'(i);
            if (!found && rx_valid[idx]) begin
                found  = 1'b1;
                winner = idx;
            end
        end
    end

    assign wr.valid = found;
    assign wr.entry = '{chan: winner, data: rx_data[winner]};

    // Only the winner sees ready, and only if the buffer has room.
    always_comb begin
        rx_ready = '0;
        if (found && wr.ready) begin
            rx_ready[winner] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr <= '0;
        end else if (wr.valid && wr.ready) begin
            ptr <= winner + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    a_one_grant: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(rx_ready)
    );

endmodule

// ==== logic/rx_buffer.sv ====
`timescale 1ns/1ps

module rx_buffer (
    input  logic                    clk,
    input  logic                    rst,
    buffer_write_if.buffer          wr,
    output logic                    out_valid,
    input  logic                    out_ready,
    output uart_hub_pkg::rx_entry_t out_entry
);

    uart_hub_pkg::rx_entry_t mem [uart_hub_pkg::buffer_depth];

    logic [uart_hub_pkg::addr_width-1:0]  wr_ptr;
    logic [uart_hub_pkg::addr_width-1:0]  rd_ptr;
    logic [uart_hub_pkg::count_width-1:0] count;
    logic                                 push;
    logic                                 pop;

    // ------------------------------------------------------------------------
    // Status and handshakes
    // ------------------------------------------------------------------------

    assign wr.ready  = (count != uart_hub_pkg::count_width'(uart_hub_pkg::buffer_depth));
    assign out_valid = (count != '0);
    assign out_entry = mem[rd_ptr];     // Head of the queue.

    assign push = wr.valid && wr.ready;
    assign pop  = out_valid && out_ready;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr.entry;
        end
    end

    // Pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // Idle, or write and pop together.
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------

    a_count_max: assert property (
        @(posedge clk) disable iff (rst)
        count <= uart_hub_pkg::count_width'(uart_hub_pkg::buffer_depth)
    );

    // Head entry must not move while the host is stalled.
    a_head_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_entry)
    );

endmodule

// ==== logic/uart_rx_hub.sv ====
`timescale 1ns/1ps

module uart_rx_hub (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic [uart_hub_pkg::num_channels-1:0]   rxd,
    input  logic [uart_hub_pkg::prescale_width-1:0] prescale,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output uart_hub_pkg::rx_entry_t                 out_entry,
    output logic [uart_hub_pkg::num_channels-1:0]   busy,
    output logic [uart_hub_pkg::num_channels-1:0]   frame_error,
    output logic [uart_hub_pkg::num_channels-1:0]   overrun_error
);

    logic [uart_hub_pkg::num_channels-1:0] rx_valid;
    logic [uart_hub_pkg::num_channels-1:0] rx_ready;
    logic [uart_hub_pkg::num_channels-1:0][uart_hub_pkg::data_width-1:0] rx_data;

    buffer_write_if wr_bus ();

    // ------------------------------------------------------------------------
    // Receivers
    // ------------------------------------------------------------------------

    for (genvar ch = 0; ch < uart_hub_pkg::num_channels; ch++) begin : g_rx
        uart_rx u_rx (
            .clk           (clk),
            .rst           (rst),
            .rxd           (rxd[ch]),
            .prescale      (prescale),      // Shared bit rate.
            .rx_data       (rx_data[ch]),
            .rx_valid      (rx_valid[ch]),
            .rx_ready      (rx_ready[ch]),
            .busy          (busy[ch]),
            .frame_error   (frame_error[ch]),
            .overrun_error (overrun_error[ch])
        );
    end

    // ------------------------------------------------------------------------
    // Arbiter and shared buffer
    // ------------------------------------------------------------------------

    write_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .rx_ready (rx_ready),
        .wr       (wr_bus.arbiter)
    );

    rx_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr_bus.buffer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_entry (out_entry)
    );

endmodule

// ==== sim/uart_rx_hub_tb.sv ====
`timescale 1ns/1ps

module uart_rx_hub_tb;

    localparam int prescale_value = 2;
    localparam int bit_cycles     = 8 * prescale_value;
    localparam int no_limit       = 1 << 20;

    typedef logic [uart_hub_pkg::data_width:0] char_t;      // Stop level above the byte.
    typedef char_t                   char_q_t[$];
    typedef uart_hub_pkg::rx_entry_t entry_q_t[$];

    logic                                    clk;
    logic                                    rst;
    logic [uart_hub_pkg::num_channels-1:0]   rxd;
    logic [uart_hub_pkg::prescale_width-1:0] prescale;
    logic                                    out_valid;
    logic                                    out_ready;
    uart_hub_pkg::rx_entry_t                 out_entry;
    logic [uart_hub_pkg::num_channels-1:0]   busy;
    logic [uart_hub_pkg::num_channels-1:0]   frame_error;
    logic [uart_hub_pkg::num_channels-1:0]   overrun_error;

    char_q_t  sent_q    [uart_hub_pkg::num_channels];
    entry_q_t expect_q  [uart_hub_pkg::num_channels];
    int       fe_count  [uart_hub_pkg::num_channels];
    int       ov_count  [uart_hub_pkg::num_channels];
    int       fe_base   [uart_hub_pkg::num_channels];
    int       ov_base   [uart_hub_pkg::num_channels];
    int       fe_expect [uart_hub_pkg::num_channels];
    int       ov_expect [uart_hub_pkg::num_channels];
    int       seed;

    uart_rx_hub UUT (
        .clk           (clk),
        .rst           (rst),
        .rxd           (rxd),
        .prescale      (prescale),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_entry     (out_entry),
        .busy          (busy),
        .frame_error   (frame_error),
        .overrun_error (overrun_error)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ------------------------------------------------------------------------
    // Reporting and checks
    // ------------------------------------------------------------------------

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_entry(input string name, input uart_hub_pkg::rx_entry_t actual,
                               input uart_hub_pkg::rx_entry_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%03h, expected 0x%03h",
                                     name, actual, expected));
        end
    endtask

    task automatic check_flag(input string name,
                              input logic [uart_hub_pkg::num_channels-1:0] actual,
                              input logic [uart_hub_pkg::num_channels-1:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        if (actual != expected) begin
            report_failure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Expected entries of one channel. A stalled host leaves each channel a
    // quarter of the buffer, then one held byte that newer bytes replace.
    function automatic void model_channel(
        input  int       ch,
        input  char_q_t  sent,
        input  bit       host_stalled,
        output entry_q_t expected,
        output int       overruns,
        output int       frames
    );
        int                                slots;
        int                                placed;
        bit                                holding;
        logic [uart_hub_pkg::data_width-1:0] held;
        slots    = host_stalled ? uart_hub_pkg::buffer_depth / uart_hub_pkg::num_channels
                                : no_limit;
        expected = {};
        overruns = 0;
        frames   = 0;
        placed   = 0;
        holding  = 1'b0;
        held     = '0;
        foreach (sent[i]) begin
            if (!sent[i][uart_hub_pkg::data_width]) begin
                frames++;                               // Bad stop bit, no byte.
            end else if (placed < slots) begin
                expected.push_back(uart_hub_pkg::rx_entry_t'{chan: ch[1:0],
                                                             data: sent[i][7:0]});
                placed++;
            end else if (!holding) begin
                holding = 1'b1;
                held    = sent[i][7:0];
            end else begin
                held = sent[i][7:0];
                overruns++;
            end
        end
        if (holding) begin
            expected.push_back(uart_hub_pkg::rx_entry_t'{chan: ch[1:0], data: held});
        end
    endfunction

    function automatic int pending_entries();
        int total;
        total = 0;
        foreach (expect_q[ch]) begin
            total += expect_q[ch].size();
        end
        return total;
    endfunction

    // ------------------------------------------------------------------------
    // Host reader and error monitor
    // ------------------------------------------------------------------------

    initial begin : host_reader
        uart_hub_pkg::rx_entry_t want;
        forever begin
            @(negedge clk);
            if (out_valid && out_ready) begin   // Pops on the next rising edge.
                if (expect_q[out_entry.chan].size() == 0) begin
                    report_failure($sformatf("An entry arrived on channel %0d, none expected.",
                                             out_entry.chan));
                end
                want = expect_q[out_entry.chan].pop_front();
                check_entry("out_entry", out_entry, want);
            end
        end
    end

    initial begin : error_monitor
        foreach (fe_count[ch]) begin
            fe_count[ch] = 0;
            ov_count[ch] = 0;
        end
        forever begin
            @(negedge clk);
            for (int ch = 0; ch < uart_hub_pkg::num_channels; ch++) begin
                if (frame_error[ch]) fe_count[ch]++;
                if (overrun_error[ch]) ov_count[ch]++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Wait n rising edges and land 1 ns after the last one.
    task automatic hold_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // A low stop bit is released early so its tail is not taken as a new start.
    task automatic send_char(input int ch, input char_t c);
        rxd[ch] = 1'b0;
        hold_cycles(bit_cycles);
        for (int i = 0; i < uart_hub_pkg::data_width; i++) begin
            rxd[ch] = c[i];                             // LSB first.
            hold_cycles(bit_cycles);
        end
        rxd[ch] = c[uart_hub_pkg::data_width];
        hold_cycles(bit_cycles * 3 / 4);
        rxd[ch] = 1'b1;
        hold_cycles(bit_cycles / 4);
    endtask

    task automatic send_list(input int ch);
        for (int i = 0; i < sent_q[ch].size(); i++) begin
            send_char(ch, sent_q[ch][i]);
        end
    endtask

    task automatic glitch_line(input int ch);
        rxd[ch] = 1'b0;
        hold_cycles(3);
        rxd[ch] = 1'b1;
    endtask

    task automatic queue_char(input int ch, input logic stop);
        logic [31:0] rnd;
        rnd = $random(seed);
        sent_q[ch].push_back({stop, rnd[7:0]});
    endtask

    // Run the model on the queued characters, then drive all lines at once.
    task automatic drive_queued(input bit host_stalled);
        entry_q_t list;
        for (int ch = 0; ch < uart_hub_pkg::num_channels; ch++) begin
            model_channel(ch, sent_q[ch], host_stalled, list, ov_expect[ch], fe_expect[ch]);
            foreach (list[i]) expect_q[ch].push_back(list[i]);
            fe_base[ch] = fe_count[ch];
            ov_base[ch] = ov_count[ch];
        end
        fork
            send_list(0);
            send_list(1);
            send_list(2);
            send_list(3);
        join
        foreach (sent_q[ch]) sent_q[ch].delete();
    endtask

    task automatic finish_test(input string name);
        int cycles;
        cycles = 0;
        while (pending_entries() != 0) begin
            if (cycles == 2000) report_failure({name, ": entries never reached the host."});
            hold_cycles(1);
            cycles++;
        end
        cycles = 0;
        while (busy != '0) begin
            if (cycles == 200) report_failure({name, ": a receiver never returned to idle."});
            hold_cycles(1);
            cycles++;
        end
        hold_cycles(bit_cycles);
        check_flag("busy", busy, '0);
        for (int ch = 0; ch < uart_hub_pkg::num_channels; ch++) begin
            check_count($sformatf("frame_error[%0d] pulses", ch),
                        fe_count[ch] - fe_base[ch], fe_expect[ch]);
            check_count($sformatf("overrun_error[%0d] pulses", ch),
                        ov_count[ch] - ov_base[ch], ov_expect[ch]);
        end
        $display("%s done.", name);
    endtask

    // ------------------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------------------

    initial begin : main_sequence
        rst       = 1'b1;
        rxd       = '1;
        prescale  = uart_hub_pkg::prescale_width'(prescale_value);
        out_ready = 1'b0;
        seed      = 27954;
        hold_cycles(4);
        rst = 1'b0;
        hold_cycles(2);
        check_flag("out_valid", {3'b000, out_valid}, '0);
        check_flag("busy", busy, '0);
        check_flag("frame_error", frame_error, '0);
        check_flag("overrun_error", overrun_error, '0);
        out_ready = 1'b1;

        queue_char(0, 1'b1);
        drive_queued(1'b0);
        finish_test("Single byte");

        repeat (6) begin
            for (int ch = 0; ch < uart_hub_pkg::num_channels; ch++) queue_char(ch, 1'b1);
        end
        drive_queued(1'b0);
        finish_test("All channels");

        queue_char(2, 1'b0);
        queue_char(2, 1'b1);
        drive_queued(1'b0);
        finish_test("Frame error");

        out_ready = 1'b0;                               // Host stalls, buffer fills.
        repeat (7) begin
            for (int ch = 0; ch < uart_hub_pkg::num_channels; ch++) queue_char(ch, 1'b1);
        end
        drive_queued(1'b1);
        out_ready = 1'b1;
        finish_test("Overrun");

        drive_queued(1'b0);                             // Nothing queued, zero expectations.
        glitch_line(1);
        finish_test("Glitch");

        if (!out_valid) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure("The buffer still holds entries at the end of the run.");
        end
    end

endmodule

// ==== build.f ====
logic/uart_hub_pkg.sv
logic/buffer_write_if.sv
logic/uart_rx.sv
logic/write_arbiter.sv
logic/rx_buffer.sv
logic/uart_rx_hub.sv
sim/uart_rx_hub_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = uart_rx_hub_tb
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass." && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
